// File: source/axil_wb_pkg.sv
package axil_wb_pkg;

    // bus widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    localparam int ADR_LSB = $clog2(STRB_W); // byte offset bits inside a word

    // address map
    localparam logic [ADDR_W-1:0] REG_BASE  = 32'h0000_0000;
    localparam int                REG_WORDS = 8;
    localparam int                REG_AW    = $clog2(REG_WORDS);
    localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h0000_1000;
    localparam int                RAM_WORDS = 256;
    localparam int                RAM_AW    = $clog2(RAM_WORDS);

    localparam logic [DATA_W-1:0] REGFILE_ID = 32'h5742_0001; // read-only word 0

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB_WRITE,
        ST_WB_READ,
        ST_RESP_B,
        ST_RESP_R
    } bridge_state_e;

    // master to slave
    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              wvalid;
        logic              bready;
        logic [ADDR_W-1:0] araddr;
        logic              arvalid;
        logic              rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        axil_resp_e        bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        axil_resp_e        rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] wdat;
        logic [STRB_W-1:0] sel;
        logic              we;
        logic              stb;
        logic              cyc;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdat;
        logic              ack;
        logic              err;
    } wb_rsp_t;

endpackage

// File: source/axil2wb_bridge.sv
`timescale 1ns/1ps

module axil2wb_bridge (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  axil_wb_pkg::axil_req_t axil_req_i,
    output axil_wb_pkg::axil_rsp_t axil_rsp_o,
    input  axil_wb_pkg::wb_rsp_t   wb_rsp_i,
    output axil_wb_pkg::wb_req_t   wb_req_o
);

    axil_wb_pkg::bridge_state_e state_q;

    logic write_req;
    logic read_req;
    logic wb_done;

    logic                           awready_q;
    logic                           wready_q;
    logic                           arready_q;
    logic                           bvalid_q;
    logic                           rvalid_q;
    axil_wb_pkg::axil_resp_e        bresp_q;
    axil_wb_pkg::axil_resp_e        rresp_q;
    logic [axil_wb_pkg::DATA_W-1:0] rdata_q;

    logic                           cyc_q;  // cyc and stb move together
    logic                           we_q;
    logic [axil_wb_pkg::ADDR_W-1:0] adr_q;
    logic [axil_wb_pkg::DATA_W-1:0] wdat_q;
    logic [axil_wb_pkg::STRB_W-1:0] sel_q;

    assign write_req = axil_req_i.awvalid & axil_req_i.wvalid;
    assign read_req  = axil_req_i.arvalid;
    assign wb_done   = wb_rsp_i.ack | wb_rsp_i.err;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= axil_wb_pkg::ST_IDLE;
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            arready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
            bresp_q   <= axil_wb_pkg::OKAY;
            rresp_q   <= axil_wb_pkg::OKAY;
            cyc_q     <= 1'b0;
            we_q      <= 1'b0;
        end else begin
            // readies are one-cycle pulses
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            arready_q <= 1'b0;
            case (state_q)
                axil_wb_pkg::ST_IDLE: begin
                    if (write_req) begin // writes win over reads
                        awready_q <= 1'b1;
                        wready_q  <= 1'b1;
                        cyc_q     <= 1'b1;
                        we_q      <= 1'b1;
                        state_q   <= axil_wb_pkg::ST_WB_WRITE;
                    end else if (read_req) begin
                        arready_q <= 1'b1;
                        cyc_q     <= 1'b1;
                        we_q      <= 1'b0;
                        state_q   <= axil_wb_pkg::ST_WB_READ;
                    end
                end
                axil_wb_pkg::ST_WB_WRITE: begin
                    if (wb_done) begin
                        cyc_q    <= 1'b0;
                        we_q     <= 1'b0;
                        bvalid_q <= 1'b1;
                        bresp_q  <= wb_rsp_i.err ? axil_wb_pkg::SLVERR : axil_wb_pkg::OKAY;
                        state_q  <= axil_wb_pkg::ST_RESP_B;
                    end
                end
                axil_wb_pkg::ST_WB_READ: begin
                    if (wb_done) begin
                        cyc_q    <= 1'b0;
                        rvalid_q <= 1'b1;
                        rresp_q  <= wb_rsp_i.err ? axil_wb_pkg::SLVERR : axil_wb_pkg::OKAY;
                        state_q  <= axil_wb_pkg::ST_RESP_R;
                    end
                end
                axil_wb_pkg::ST_RESP_B: begin
                    if (axil_req_i.bready) begin
                        bvalid_q <= 1'b0;
                        state_q  <= axil_wb_pkg::ST_IDLE;
                    end
                end
                axil_wb_pkg::ST_RESP_R: begin
                    if (axil_req_i.rready) begin
                        rvalid_q <= 1'b0;
                        state_q  <= axil_wb_pkg::ST_IDLE;
                    end
                end
                default: state_q <= axil_wb_pkg::ST_IDLE;
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge clk_i) begin
        if (state_q == axil_wb_pkg::ST_IDLE) begin
            if (write_req) begin
                adr_q  <= axil_req_i.awaddr;
                wdat_q <= axil_req_i.wdata;
                sel_q  <= axil_req_i.wstrb;
            end else if (read_req) begin
                adr_q <= axil_req_i.araddr;
                sel_q <= '1; // full word read
            end
        end
        if (state_q == axil_wb_pkg::ST_WB_READ && wb_done) begin
            rdata_q <= wb_rsp_i.rdat;
        end
    end

    assign axil_rsp_o.awready = awready_q;
    assign axil_rsp_o.wready  = wready_q;
    assign axil_rsp_o.bvalid  = bvalid_q;
    assign axil_rsp_o.bresp   = bresp_q;
    assign axil_rsp_o.arready = arready_q;
    assign axil_rsp_o.rvalid  = rvalid_q;
    assign axil_rsp_o.rdata   = rdata_q;
    assign axil_rsp_o.rresp   = rresp_q;

    assign wb_req_o.adr  = adr_q;
    assign wb_req_o.wdat = wdat_q;
    assign wb_req_o.sel  = sel_q;
    assign wb_req_o.we   = we_q;
    assign wb_req_o.stb  = cyc_q;
    assign wb_req_o.cyc  = cyc_q;

endmodule

// File: source/wb_addr_decoder.sv
`timescale 1ns/1ps

module wb_addr_decoder (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  axil_wb_pkg::wb_req_t wb_req_i,
    output axil_wb_pkg::wb_rsp_t wb_rsp_o,
    output axil_wb_pkg::wb_req_t reg_req_o,
    output axil_wb_pkg::wb_req_t ram_req_o,
    input  axil_wb_pkg::wb_rsp_t reg_rsp_i,
    input  axil_wb_pkg::wb_rsp_t ram_rsp_i
);

    logic [axil_wb_pkg::ADDR_W-1:0] reg_off;
    logic [axil_wb_pkg::ADDR_W-1:0] ram_off;
    logic                           reg_hit;
    logic                           ram_hit;
    logic                           active;
    logic                           err_q;

    // offsets wrap below the base, so one compare covers both bounds
    assign reg_off = wb_req_i.adr - axil_wb_pkg::REG_BASE;
    assign ram_off = wb_req_i.adr - axil_wb_pkg::RAM_BASE;
    assign reg_hit = reg_off <
        axil_wb_pkg::ADDR_W'(axil_wb_pkg::REG_WORDS * axil_wb_pkg::STRB_W);
    assign ram_hit = ram_off <
        axil_wb_pkg::ADDR_W'(axil_wb_pkg::RAM_WORDS * axil_wb_pkg::STRB_W);

    assign active = wb_req_i.cyc & wb_req_i.stb;

    always_comb begin
        reg_req_o     = wb_req_i;
        reg_req_o.cyc = wb_req_i.cyc & reg_hit;
        reg_req_o.stb = wb_req_i.stb & reg_hit;
        ram_req_o     = wb_req_i;
        ram_req_o.cyc = wb_req_i.cyc & ram_hit;
        ram_req_o.stb = wb_req_i.stb & ram_hit;
    end

    // single err pulse per unmapped cycle
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= active & ~reg_hit & ~ram_hit & ~err_q;
        end
    end

    always_comb begin
        if (reg_hit) begin
            wb_rsp_o = reg_rsp_i;
        end else if (ram_hit) begin
            wb_rsp_o = ram_rsp_i;
        end else begin
            wb_rsp_o.rdat = '0;
            wb_rsp_o.ack  = 1'b0;
            wb_rsp_o.err  = err_q;
        end
    end

endmodule

// File: source/wb_regfile.sv
`timescale 1ns/1ps

module wb_regfile (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  axil_wb_pkg::wb_req_t           wb_req_i,
    output axil_wb_pkg::wb_rsp_t           wb_rsp_o,
    output logic [axil_wb_pkg::DATA_W-1:0] ctrl_o
);

    // word 0 has no storage
    logic [axil_wb_pkg::DATA_W-1:0] regs_q [1:axil_wb_pkg::REG_WORDS-1];
    logic [axil_wb_pkg::REG_AW-1:0] idx;
    logic                           req_new;
    logic                           id_write;
    logic                           ack_q;
    logic                           err_q;
    logic [axil_wb_pkg::DATA_W-1:0] rdat_q;

    assign idx = wb_req_i.adr[axil_wb_pkg::ADR_LSB +: axil_wb_pkg::REG_AW];

    // a cycle not answered yet
    assign req_new  = wb_req_i.cyc & wb_req_i.stb & ~ack_q & ~err_q;
    assign id_write = wb_req_i.we & (idx == '0);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req_new & ~id_write;
            err_q <= req_new & id_write;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < axil_wb_pkg::REG_WORDS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (req_new && wb_req_i.we && idx != '0) begin
            for (int b = 0; b < axil_wb_pkg::STRB_W; b++) begin
                if (wb_req_i.sel[b]) begin
                    regs_q[idx][8*b +: 8] <= wb_req_i.wdat[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_new) begin
            if (wb_req_i.we) begin
                rdat_q <= '0; // nothing to return on writes
            end else if (idx == '0) begin
                rdat_q <= axil_wb_pkg::REGFILE_ID;
            end else begin
                rdat_q <= regs_q[idx];
            end
        end
    end

    assign wb_rsp_o.rdat = rdat_q;
    assign wb_rsp_o.ack  = ack_q;
    assign wb_rsp_o.err  = err_q;

    assign ctrl_o = regs_q[1];

endmodule

// File: source/wb_scratch_ram.sv
`timescale 1ns/1ps

module wb_scratch_ram (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  axil_wb_pkg::wb_req_t wb_req_i,
    output axil_wb_pkg::wb_rsp_t wb_rsp_o
);

    logic [axil_wb_pkg::DATA_W-1:0] mem [axil_wb_pkg::RAM_WORDS];
    logic [axil_wb_pkg::RAM_AW-1:0] idx;
    logic                           req_new;
    logic                           wait_q;
    logic                           ack_q;
    logic [axil_wb_pkg::DATA_W-1:0] rdat_q;

    assign idx     = wb_req_i.adr[axil_wb_pkg::ADR_LSB +: axil_wb_pkg::RAM_AW];
    assign req_new = wb_req_i.cyc & wb_req_i.stb & ~wait_q & ~ack_q;

    // one wait state before ack
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wait_q <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            wait_q <= req_new;
            ack_q  <= wait_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_new) begin
            rdat_q <= mem[idx];
            if (wb_req_i.we) begin
                for (int b = 0; b < axil_wb_pkg::STRB_W; b++) begin
                    if (wb_req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= wb_req_i.wdat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign wb_rsp_o.rdat = rdat_q;
    assign wb_rsp_o.ack  = ack_q;
    assign wb_rsp_o.err  = 1'b0; // every word is mapped

endmodule

// File: source/axil_wb_top.sv
`timescale 1ns/1ps

module axil_wb_top (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  axil_wb_pkg::axil_req_t         axil_req_i,
    output axil_wb_pkg::axil_rsp_t         axil_rsp_o,
    output logic [axil_wb_pkg::DATA_W-1:0] ctrl_o
);

    axil_wb_pkg::wb_req_t wb_req;
    axil_wb_pkg::wb_rsp_t wb_rsp;
    axil_wb_pkg::wb_req_t reg_req;
    axil_wb_pkg::wb_rsp_t reg_rsp;
    axil_wb_pkg::wb_req_t ram_req;
    axil_wb_pkg::wb_rsp_t ram_rsp;

    axil2wb_bridge i_bridge (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .wb_rsp_i   (wb_rsp),
        .wb_req_o   (wb_req)
    );

    wb_addr_decoder i_decoder (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .reg_req_o (reg_req),
        .ram_req_o (ram_req),
        .reg_rsp_i (reg_rsp),
        .ram_rsp_i (ram_rsp)
    );

    wb_regfile i_regfile (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wb_req_i (reg_req),
        .wb_rsp_o (reg_rsp),
        .ctrl_o   (ctrl_o)
    );

    wb_scratch_ram i_ram (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wb_req_i (ram_req),
        .wb_rsp_o (ram_rsp)
    );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    localparam int HALF_PERIOD  = 20; // half of the 40 ns period
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

// File: verification/axil_wb_tb.sv
`timescale 1ns/1ps

module axil_wb_tb;

    localparam int TIMEOUT = 40; // cycles per handshake

    logic                    clk;
    logic                    rstn;
    axil_wb_pkg::axil_req_t  req;
    axil_wb_pkg::axil_rsp_t  rsp;
    logic [31:0]             ctrl;
    logic [31:0]             reg_model [axil_wb_pkg::REG_WORDS];
    logic [31:0]             ram_model [axil_wb_pkg::RAM_WORDS];
    logic [31:0]             exp_rdata;
    logic [31:0]             exp_ctrl;
    axil_wb_pkg::axil_resp_e exp_bresp;
    axil_wb_pkg::axil_resp_e exp_rresp;
    logic                    req_seen;
    logic                    pend_w; // ready seen but response not yet taken
    logic                    pend_r;
    integer                  seed;

    tb_clk_gen i_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    axil_wb_top i_dut (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .axil_req_i (req),
        .axil_rsp_o (rsp),
        .ctrl_o     (ctrl)
    );

    task automatic fail_value(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic fail_timeout(input string what);
        $display("the %s handshake never completed (time %0t ns)", what, $time);
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            pend_w <= 1'b0;
            pend_r <= 1'b0;
        end else begin
            if (rsp.awready) pend_w <= 1'b1;
            else if (rsp.bvalid && req.bready) pend_w <= 1'b0;
            if (rsp.arready) pend_r <= 1'b1;
            else if (rsp.rvalid && req.rready) pend_r <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) !req_seen |->
        !(rsp.awready || rsp.wready || rsp.arready || rsp.bvalid || rsp.rvalid))
        else fail_value("bus active before the first request");
    assert property (@(posedge clk) disable iff (!rstn) rsp.awready == rsp.wready)
        else fail_value("awready and wready not in the same cycle");
    assert property (@(posedge clk) disable iff (!rstn)
        (rsp.awready || rsp.arready) |-> !pend_w && !pend_r)
        else fail_value("ready raised again before the response was taken");
    assert property (@(posedge clk) disable iff (!rstn) $rose(rsp.bvalid) |-> pend_w)
        else fail_value("bvalid rose without a write handshake");
    assert property (@(posedge clk) disable iff (!rstn) $rose(rsp.rvalid) |-> pend_r)
        else fail_value("rvalid rose without a read handshake");
    assert property (@(posedge clk) disable iff (!rstn)
        (rsp.bvalid || rsp.rvalid) |-> !(rsp.awready || rsp.wready || rsp.arready))
        else fail_value("ready raised while a response waits");
    assert property (@(posedge clk) disable iff (!rstn)
        rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
        else fail_value("write response changed before bready");
    assert property (@(posedge clk) disable iff (!rstn) rsp.rvalid && !req.rready |=>
        rsp.rvalid && $stable(rsp.rresp) && $stable(rsp.rdata))
        else fail_value("read response changed before rready");
    assert property (@(posedge clk) disable iff (!rstn)
        rsp.bvalid && req.bready |-> rsp.bresp == exp_bresp)
        else fail_value("wrong bresp");
    assert property (@(posedge clk) disable iff (!rstn)
        rsp.rvalid && req.rready |-> rsp.rdata == exp_rdata && rsp.rresp == exp_rresp)
        else fail_value("wrong rdata or rresp");
    assert property (@(posedge clk) disable iff (!rstn) rsp.bvalid |-> ctrl == exp_ctrl)
        else fail_value("ctrl_o differs from word 1");

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, new_w,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // both windows are aligned to their size
    function automatic bit in_reg(input logic [31:0] a);
        return (a >> 5) == (axil_wb_pkg::REG_BASE >> 5);
    endfunction

    function automatic bit in_ram(input logic [31:0] a);
        return (a >> 10) == (axil_wb_pkg::RAM_BASE >> 10);
    endfunction

    // 0 awready, 1 arready, 2 bvalid, 3 rvalid
    task automatic wait_flag(input int which, input string what);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!(which == 0 ? rsp.awready : which == 1 ? rsp.arready :
                 which == 2 ? rsp.bvalid : rsp.rvalid)) begin
            if (cnt == TIMEOUT) fail_timeout(what);
            cnt++;
            @(negedge clk);
        end
    endtask

    task automatic start_write(input logic [31:0] addr, data, input logic [3:0] strb);
        if (in_reg(addr) && addr[4:2] != 3'd0) begin
            reg_model[addr[4:2]] = merge_bytes(reg_model[addr[4:2]], data, strb);
            exp_bresp = axil_wb_pkg::OKAY;
        end else if (in_ram(addr)) begin
            ram_model[addr[9:2]] = merge_bytes(ram_model[addr[9:2]], data, strb);
            exp_bresp = axil_wb_pkg::OKAY;
        end else begin
            exp_bresp = axil_wb_pkg::SLVERR; // id word or unmapped
        end
        exp_ctrl = reg_model[1];
        @(posedge clk);
        req.awaddr  <= addr;
        req.wdata   <= data;
        req.wstrb   <= strb;
        req.awvalid <= 1'b1;
        req.wvalid  <= 1'b1;
        req_seen    <= 1'b1;
        wait_flag(0, "write address");
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
    endtask

    task automatic raise_read(input logic [31:0] addr);
        exp_rresp = axil_wb_pkg::OKAY;
        if (in_reg(addr)) begin
            exp_rdata = (addr[4:2] == 3'd0) ? axil_wb_pkg::REGFILE_ID : reg_model[addr[4:2]];
        end else if (in_ram(addr)) begin
            exp_rdata = ram_model[addr[9:2]];
        end else begin
            exp_rdata = '0;
            exp_rresp = axil_wb_pkg::SLVERR;
        end
        @(posedge clk);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        req_seen    <= 1'b1;
    endtask

    task automatic take_read();
        wait_flag(1, "read address");
        @(posedge clk);
        req.arvalid <= 1'b0;
    endtask

    task automatic accept_resp(input bit is_read, input int delay);
        wait_flag(is_read ? 3 : 2, is_read ? "read response" : "write response");
        repeat (delay) @(negedge clk); // back-pressure
        @(posedge clk);
        if (is_read) req.rready <= 1'b1;
        else req.bready <= 1'b1;
        @(posedge clk);
        req.rready <= 1'b0;
        req.bready <= 1'b0;
    endtask

    task automatic do_write(input logic [31:0] addr, data, input logic [3:0] strb,
                            input int delay);
        start_write(addr, data, strb);
        accept_resp(1'b0, delay);
    endtask

    task automatic do_read(input logic [31:0] addr, input int delay);
        raise_read(addr);
        take_read();
        accept_resp(1'b1, delay);
    endtask

    initial begin
        int          cnt;
        logic [31:0] addr;
        seed      = 32'h74f8;
        req       = '0;
        req_seen  = 1'b0;
        exp_ctrl  = '0;
        exp_rdata = '0;
        exp_bresp = axil_wb_pkg::OKAY;
        exp_rresp = axil_wb_pkg::OKAY;
        for (int i = 0; i < axil_wb_pkg::REG_WORDS; i++) reg_model[i] = '0;
        cnt = 0;
        while (rstn !== 1'b1) begin
            if (cnt == TIMEOUT) fail_timeout("reset release");
            cnt++;
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        do_read(axil_wb_pkg::REG_BASE, 0);
        do_write(axil_wb_pkg::REG_BASE, $random(seed), 4'hf, 1); // id word is read-only
        do_read(axil_wb_pkg::REG_BASE, 2);
        for (int i = 0; i < 24; i++) begin
            addr = axil_wb_pkg::REG_BASE + 4 * (1 + rand_below(7));
            do_write(addr, $random(seed), 4'(rand_below(16)), rand_below(4));
            do_read(addr, rand_below(4));
        end

        // fill pattern over the whole byte address
        for (int i = 0; i < axil_wb_pkg::RAM_WORDS; i++) begin
            addr = axil_wb_pkg::RAM_BASE + 4 * i;
            do_write(addr, {~addr[15:0], addr[15:0]} ^ 32'h3c5a_96e1, 4'hf, 0);
        end
        for (int i = 0; i < 40; i++) begin
            addr = axil_wb_pkg::RAM_BASE + 4 * rand_below(axil_wb_pkg::RAM_WORDS);
            do_write(addr, $random(seed), 4'(rand_below(16)), rand_below(4));
            do_read(addr, rand_below(4));
            do_read(axil_wb_pkg::RAM_BASE + 4 * rand_below(axil_wb_pkg::RAM_WORDS), 0);
        end

        for (int i = 0; i < 6; i++) begin
            addr = (i == 0) ? 32'h0000_0020 : (i == 1) ? 32'h0000_1400 :
                   {1'b1, 29'($random(seed)), 2'b00};
            do_write(addr, $random(seed), 4'hf, rand_below(3));
            do_read(addr, rand_below(3));
        end

        // read request held valid while the write response is stalled
        for (int i = 0; i < 12; i++) begin
            addr = (i % 2) ? axil_wb_pkg::RAM_BASE + 4 * rand_below(axil_wb_pkg::RAM_WORDS)
                           : axil_wb_pkg::REG_BASE + 4 * (1 + rand_below(7));
            start_write(addr, $random(seed), 4'(rand_below(16)));
            raise_read(addr);
            accept_resp(1'b0, 1 + rand_below(8));
            take_read();
            accept_resp(1'b1, 1 + rand_below(8));
        end

        repeat (2) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

// File: flist.f
source/axil_wb_pkg.sv
source/axil2wb_bridge.sv
source/wb_addr_decoder.sv
source/wb_regfile.sv
source/wb_scratch_ram.sv
source/axil_wb_top.sv
verification/tb_clk_gen.sv
verification/axil_wb_tb.sv

// File: Bender.yml
package:
  name: axil_wb

sources:
  - source/axil_wb_pkg.sv
  - source/axil2wb_bridge.sv
  - source/wb_addr_decoder.sv
  - source/wb_regfile.sv
  - source/wb_scratch_ram.sv
  - source/axil_wb_top.sv
  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/axil_wb_tb.sv
